//--- design/vec_csr_consts.svh
// shared constants for the vector CSR block
// data width, vector length in bytes, CSR address map
// and the exception codes seen on the commit port

`ifndef VEC_CSR_CONSTS_SVH
`define VEC_CSR_CONSTS_SVH

// ------------------------------------------------------------
// widths
// ------------------------------------------------------------
`define VEC_XLEN  64
`define VEC_VLENB 16  // VLEN 128

// ------------------------------------------------------------
// CSR addresses
// ------------------------------------------------------------
`define VEC_CSR_ADDR_VSTART   12'h008
`define VEC_CSR_ADDR_VXSAT    12'h009
`define VEC_CSR_ADDR_VXRM     12'h00A
`define VEC_CSR_ADDR_VCSR     12'h00F
`define VEC_CSR_ADDR_VL       12'hC20
`define VEC_CSR_ADDR_VTYPE    12'hC21
`define VEC_CSR_ADDR_VLENB    12'hC22
`define VEC_CSR_ADDR_VSCRATCH 12'h800  // custom, user r/w space

// exception codes on the commit port
`define VEC_EXC_LMUL_CHANGE 4'd1
`define VEC_EXC_MRET        4'd2
`define VEC_EXC_SRET        4'd3
`define VEC_EXC_URET        4'd4

`endif

//--- design/vec_csr_pkg.sv
// types shared by the vector CSR block
// CSR data word, vtype layout, commit exception type

`include "vec_csr_consts.svh"

package vec_csr_pkg;

  // one CSR word
  typedef logic [`VEC_XLEN-1:0] xlen_t;

  // ------------------------------------------------------------
  // vtype register layout, msb first
  // ------------------------------------------------------------
  typedef struct packed {
    logic        vill;
    logic [54:0] reserved;
    logic        vma;
    logic        vta;
    logic [2:0]  vsew;   // 0:e8 1:e16 2:e32 3:e64
    logic [2:0]  vlmul;  // 0..3 integer, 5..7 fractional, 4 reserved
  } vtype_t;

  // exception type carried by a commit
  typedef enum logic [3:0] {
    EXC_NONE        = 4'd0,
    EXC_LMUL_CHANGE = `VEC_EXC_LMUL_CHANGE,
    EXC_MRET        = `VEC_EXC_MRET,
    EXC_SRET        = `VEC_EXC_SRET,
    EXC_URET        = `VEC_EXC_URET
  } except_type_t;

endpackage

//--- design/vsetvl_unit.sv
// vsetvl unit
// decodes the requested vtype, computes vlmax and the vill check,
// clamps avl to vlmax and registers the result as a one-cycle
// done pulse that doubles as the CSR update strobe

`timescale 1ns/10ps

`include "vec_csr_consts.svh"

module vsetvl_unit (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_vset_valid,
  input  vec_csr_pkg::xlen_t   i_vset_avl,
  input  vec_csr_pkg::xlen_t   i_vset_vtype,
  output logic                 o_vset_done,
  output logic [7:0]           o_vset_vl,
  output logic                 o_upd_valid,
  output logic [7:0]           o_upd_vl,
  output vec_csr_pkg::vtype_t  o_upd_vtype
);

  import vec_csr_pkg::*;

  vtype_t      w_req;
  logic [7:0]  w_vlenb;
  logic [7:0]  w_vlmax;
  logic        w_vill;
  logic [7:0]  w_grant_vl;
  vtype_t      w_grant_vtype;

  logic        r_done;
  logic [7:0]  r_vl;
  vtype_t      r_vtype;

  assign w_req   = vtype_t'(i_vset_vtype);
  assign w_vlenb = 8'(`VEC_VLENB);

  // ------------------------------------------------------------
  // vlmax from vlmul and vsew
  // ------------------------------------------------------------
  always_comb begin
    case (w_req.vlmul)
      3'd0, 3'd1, 3'd2, 3'd3 : w_vlmax = (w_vlenb << w_req.vlmul) >> w_req.vsew;
      3'd5, 3'd6, 3'd7       : w_vlmax = (w_vlenb >> (4'd8 - {1'b0, w_req.vlmul})) >> w_req.vsew;
      default                : w_vlmax = 8'd0;  // vlmul 4 reserved
    endcase
  end

  assign w_vill = (w_req.vlmul == 3'd4) |
                  (w_req.vsew > 3'd3)   |
                  (|w_req.reserved)     |
                  (w_vlmax == 8'd0);      // e.g. mf8 with e64

  // vl = min(avl, vlmax)
  always_comb begin
    if (w_vill) begin
      w_grant_vl    = 8'd0;
      w_grant_vtype = '{vill: 1'b1, default: '0};
    end else begin
      w_grant_vl    = (i_vset_avl < xlen_t'(w_vlmax)) ? i_vset_avl[7:0] : w_vlmax;
      w_grant_vtype = w_req;
      w_grant_vtype.vill = 1'b0;
    end
  end

  // ------------------------------------------------------------
  // result register
  // ------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_done <= 1'b0;
    end else begin
      r_done <= i_vset_valid;  // one pulse per strobe
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_vset_valid) begin
      r_vl    <= w_grant_vl;
      r_vtype <= w_grant_vtype;
    end
  end

  assign o_vset_done = r_done;
  assign o_vset_vl   = r_vl;
  assign o_upd_valid = r_done;
  assign o_upd_vl    = r_vl;
  assign o_upd_vtype = r_vtype;

endmodule

//--- design/vec_csr_file.sv
// vector CSR register file
// combinational read mux with error, strobed write with error,
// vl/vtype loaded from the vsetvl unit, LMUL exception mode
// and vscratch capture from flushed commits

`timescale 1ns/10ps

`include "vec_csr_consts.svh"

module vec_csr_file (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  // read port
  input  logic                       i_rd_valid,
  input  logic [11:0]                i_rd_addr,
  output vec_csr_pkg::xlen_t         o_rd_data,
  output logic                       o_rd_error,
  // write port
  input  logic                       i_wr_valid,
  input  logic [11:0]                i_wr_addr,
  input  vec_csr_pkg::xlen_t         i_wr_data,
  output logic                       o_wr_error,
  // update from vsetvl
  input  logic                       i_upd_valid,
  input  logic [7:0]                 i_upd_vl,
  input  vec_csr_pkg::vtype_t        i_upd_vtype,
  // commit monitor
  input  logic                       i_commit_valid,
  input  logic                       i_commit_flush,
  input  vec_csr_pkg::except_type_t  i_commit_except_type,
  input  vec_csr_pkg::xlen_t         i_commit_tval,
  output logic                       o_lmul_exception_mode
);

  import vec_csr_pkg::*;

  xlen_t       r_vstart;
  logic [1:0]  r_vxrm;
  logic        r_vxsat;
  logic [7:0]  r_vl;
  vtype_t      r_vtype;
  xlen_t       r_vscratch;
  logic        r_lmul_exception_mode;

  logic        w_wr_accept;
  logic        w_flushed_commit;

  // ------------------------------------------------------------
  // read mux
  // ------------------------------------------------------------
  always_comb begin
    o_rd_data  = '0;
    o_rd_error = 1'b0;
    if (i_rd_valid) begin
      case (i_rd_addr)
        `VEC_CSR_ADDR_VSTART   : o_rd_data = r_vstart;
        `VEC_CSR_ADDR_VXSAT    : o_rd_data = xlen_t'(r_vxsat);
        `VEC_CSR_ADDR_VXRM     : o_rd_data = xlen_t'(r_vxrm);
        `VEC_CSR_ADDR_VCSR     : o_rd_data = xlen_t'({r_vxrm, r_vxsat}); // vcsr view
        `VEC_CSR_ADDR_VL       : o_rd_data = xlen_t'(r_vl);
        `VEC_CSR_ADDR_VTYPE    : o_rd_data = r_vtype;
        `VEC_CSR_ADDR_VLENB    : o_rd_data = xlen_t'(`VEC_VLENB);  // constant
        `VEC_CSR_ADDR_VSCRATCH : o_rd_data = r_vscratch;
        default                : o_rd_error = 1'b1;
      endcase
    end
  end

  // ------------------------------------------------------------
  // write decode
  // ------------------------------------------------------------
  // vl, vtype, vlenb are read-only here, they fall into default
  always_comb begin
    o_wr_error = 1'b0;
    if (i_wr_valid) begin
      case (i_wr_addr)
        `VEC_CSR_ADDR_VSTART,
        `VEC_CSR_ADDR_VXSAT,
        `VEC_CSR_ADDR_VXRM,
        `VEC_CSR_ADDR_VCSR,
        `VEC_CSR_ADDR_VSCRATCH : o_wr_error = 1'b0;
        default                : o_wr_error = 1'b1;
      endcase
    end
  end

  assign w_wr_accept      = i_wr_valid & ~o_wr_error;
  assign w_flushed_commit = i_commit_valid & i_commit_flush;

  // writable CSRs and commit monitor
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_vstart              <= '0;
      r_vxrm                <= 2'b00;
      r_vxsat               <= 1'b0;
      r_vscratch            <= '0;
      r_lmul_exception_mode <= 1'b0;
    end else begin
      if (w_wr_accept) begin
        case (i_wr_addr)
          `VEC_CSR_ADDR_VSTART   : r_vstart   <= i_wr_data;
          `VEC_CSR_ADDR_VXSAT    : r_vxsat    <= i_wr_data[0];
          `VEC_CSR_ADDR_VXRM     : r_vxrm     <= i_wr_data[1:0];
          `VEC_CSR_ADDR_VCSR     : begin
            r_vxrm  <= i_wr_data[2:1];
            r_vxsat <= i_wr_data[0];
          end
          `VEC_CSR_ADDR_VSCRATCH : r_vscratch <= i_wr_data;
          default                : ;
        endcase
      end
      // commit capture comes last, wins over a write to vscratch
      if (w_flushed_commit) begin
        case (i_commit_except_type)
          EXC_LMUL_CHANGE : begin
            r_lmul_exception_mode <= 1'b1;
            r_vscratch            <= i_commit_tval;  // keep trap value
          end
          EXC_MRET,
          EXC_SRET,
          EXC_URET        : r_lmul_exception_mode <= 1'b0;
          default         : ;
        endcase
      end
    end
  end

  // vl and vtype only change through vsetvl
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_vl    <= 8'd0;
      r_vtype <= '{vill: 1'b1, default: '0};
    end else if (i_upd_valid) begin
      r_vl    <= i_upd_vl;
      r_vtype <= i_upd_vtype;
    end
  end

  assign o_lmul_exception_mode = r_lmul_exception_mode;

endmodule

//--- design/vec_csr_top.sv
// top of the vector CSR block
// vsetvl unit feeding the vector CSR file

`timescale 1ns/10ps

module vec_csr_top (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  // CSR read
  input  logic                       i_rd_valid,
  input  logic [11:0]                i_rd_addr,
  output vec_csr_pkg::xlen_t         o_rd_data,
  output logic                       o_rd_error,
  // CSR write
  input  logic                       i_wr_valid,
  input  logic [11:0]                i_wr_addr,
  input  vec_csr_pkg::xlen_t         i_wr_data,
  output logic                       o_wr_error,
  // vsetvl request
  input  logic                       i_vset_valid,
  input  vec_csr_pkg::xlen_t         i_vset_avl,
  input  vec_csr_pkg::xlen_t         i_vset_vtype,
  output logic                       o_vset_done,
  output logic [7:0]                 o_vset_vl,
  // commit
  input  logic                       i_commit_valid,
  input  logic                       i_commit_flush,
  input  vec_csr_pkg::except_type_t  i_commit_except_type,
  input  vec_csr_pkg::xlen_t         i_commit_tval,
  output logic                       o_lmul_exception_mode
);

  import vec_csr_pkg::*;

  // ------------------------------------------------------------
  // vsetvl -> CSR file update
  // ------------------------------------------------------------
  logic        upd_valid;
  logic [7:0]  upd_vl;
  vtype_t      upd_vtype;

  vsetvl_unit u_vsetvl_unit (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_vset_valid (i_vset_valid),
    .i_vset_avl   (i_vset_avl),
    .i_vset_vtype (i_vset_vtype),
    .o_vset_done  (o_vset_done),
    .o_vset_vl    (o_vset_vl),
    .o_upd_valid  (upd_valid),
    .o_upd_vl     (upd_vl),
    .o_upd_vtype  (upd_vtype)
  );

  vec_csr_file u_vec_csr_file (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .i_rd_valid            (i_rd_valid),
    .i_rd_addr             (i_rd_addr),
    .o_rd_data             (o_rd_data),
    .o_rd_error            (o_rd_error),
    .i_wr_valid            (i_wr_valid),
    .i_wr_addr             (i_wr_addr),
    .i_wr_data             (i_wr_data),
    .o_wr_error            (o_wr_error),
    .i_upd_valid           (upd_valid),
    .i_upd_vl              (upd_vl),
    .i_upd_vtype           (upd_vtype),
    .i_commit_valid        (i_commit_valid),
    .i_commit_flush        (i_commit_flush),
    .i_commit_except_type  (i_commit_except_type),
    .i_commit_tval         (i_commit_tval),
    .o_lmul_exception_mode (o_lmul_exception_mode)
  );

endmodule

//--- test/vec_csr_clkgen.sv
// clock and reset source for the vector CSR testbench
// 100 ns clock, active-low reset held for 4 cycles

`timescale 1ns/10ps

module vec_csr_clkgen (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #50 o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (4) @(posedge o_clk);
    #1 o_reset_n = 1'b1;  // release just after the 4th edge
  end

endmodule

//--- test/vec_csr_assertions.sv
// port assertions for vec_csr_top, attached with bind
// done pulse spacing, idle read data, write error qualification

`timescale 1ns/10ps

module vec_csr_assertions (
  input logic               i_clk,
  input logic               i_reset_n,
  input logic               i_rd_valid,
  input vec_csr_pkg::xlen_t o_rd_data,
  input logic               i_wr_valid,
  input logic               o_wr_error,
  input logic               i_vset_valid,
  input logic               o_vset_done
);

  int fail_count = 0;  // assertion failures so far

  // two done cycles in a row need two strobes in a row
  a_done_spacing : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_vset_done && $past(o_vset_done)) |-> ($past(i_vset_valid, 1) && $past(i_vset_valid, 2)))
    else begin
      $error("o_vset_done high in consecutive cycles without consecutive strobes");
      fail_count++;
    end

  a_rd_idle_zero : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !i_rd_valid |-> (o_rd_data == '0))
    else begin
      $error("o_rd_data not zero while i_rd_valid is low");
      fail_count++;
    end

  a_wr_error_qual : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_wr_error |-> i_wr_valid)
    else begin
      $error("o_wr_error set without i_wr_valid");
      fail_count++;
    end

endmodule

bind vec_csr_top vec_csr_assertions u_vec_csr_assertions (
  .i_clk        (i_clk),
  .i_reset_n    (i_reset_n),
  .i_rd_valid   (i_rd_valid),
  .o_rd_data    (o_rd_data),
  .i_wr_valid   (i_wr_valid),
  .o_wr_error   (o_wr_error),
  .i_vset_valid (i_vset_valid),
  .o_vset_done  (o_vset_done)
);

//--- test/vec_csr_tb.sv
// testbench for the vector CSR block
// reads operations and expected values from the stimulus file,
// drives the CSR, vsetvl and commit ports and checks the results

`timescale 1ns/10ps

`include "vec_csr_consts.svh"

module vec_csr_tb;

  import vec_csr_pkg::*;

  localparam int MAX_WAIT = 10;  // cycles

  logic         clk;
  logic         reset_n;
  logic         rd_valid;
  logic [11:0]  rd_addr;
  xlen_t        rd_data;
  logic         rd_error;
  logic         wr_valid;
  logic [11:0]  wr_addr;
  xlen_t        wr_data;
  logic         wr_error;
  logic         vset_valid;
  xlen_t        vset_avl;
  xlen_t        vset_vtype;
  logic         vset_done;
  logic [7:0]   vset_vl;
  logic         commit_valid;
  logic         commit_flush;
  except_type_t commit_except_type;
  xlen_t        commit_tval;
  logic         lmul_mode;

  vec_csr_clkgen u_clkgen (.o_clk(clk), .o_reset_n(reset_n));

  vec_csr_top u_vec_csr_top (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_rd_valid (rd_valid), .i_rd_addr (rd_addr), .o_rd_data (rd_data), .o_rd_error (rd_error),
    .i_wr_valid (wr_valid), .i_wr_addr (wr_addr), .i_wr_data (wr_data), .o_wr_error (wr_error),
    .i_vset_valid (vset_valid), .i_vset_avl (vset_avl), .i_vset_vtype (vset_vtype),
    .o_vset_done (vset_done), .o_vset_vl (vset_vl),
    .i_commit_valid (commit_valid), .i_commit_flush (commit_flush),
    .i_commit_except_type (commit_except_type), .i_commit_tval (commit_tval),
    .o_lmul_exception_mode (lmul_mode)
  );

  // ------------------------------------------------------------
  // failure reporting and checks
  // ------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_value(input string name, input xlen_t actual, input xlen_t expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
      abort_run("value check failed");
    end
  endtask

  // bound port assertions
  always @(u_vec_csr_top.u_vec_csr_assertions.fail_count) begin
    if (u_vec_csr_top.u_vec_csr_assertions.fail_count != 0) begin
      abort_run("a port assertion on vec_csr_top failed");
    end
  end

  task automatic set_idle();
    rd_valid           = 1'b0;
    rd_addr            = '0;
    wr_valid           = 1'b0;
    wr_addr            = '0;
    wr_data            = '0;
    vset_valid         = 1'b0;
    vset_avl           = '0;
    vset_vtype         = '0;
    commit_valid       = 1'b0;
    commit_flush       = 1'b0;
    commit_except_type = EXC_NONE;
    commit_tval        = '0;
  endtask

  // every op starts just after a rising edge
  task automatic next_slot();
    @(posedge clk);
    #1 set_idle();
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (reset_n !== 1'b1) begin
      @(posedge clk);
      cycles++;
      if (cycles > MAX_WAIT) abort_run("reset was never released");
    end
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (vset_done !== 1'b1) begin
      cycles++;
      if (cycles >= MAX_WAIT) abort_run("timeout waiting for o_vset_done");
      @(negedge clk);
    end
  endtask

  // ------------------------------------------------------------
  // operations
  // ------------------------------------------------------------
  task automatic read_csr(input logic [11:0] addr, input xlen_t exp_data, input logic exp_err);
    next_slot();
    rd_valid = 1'b1;
    rd_addr  = addr;
    @(negedge clk);  // combinational answer settled
    check_value("o_rd_data", rd_data, exp_data);
    check_value("o_rd_error", xlen_t'(rd_error), xlen_t'(exp_err));
  endtask

  task automatic write_csr(input logic [11:0] addr, input xlen_t data, input logic exp_err);
    next_slot();
    wr_valid = 1'b1;
    wr_addr  = addr;
    wr_data  = data;
    @(negedge clk);
    check_value("o_wr_error", xlen_t'(wr_error), xlen_t'(exp_err));
  endtask

  task automatic vset_request(input xlen_t avl, input xlen_t vtype, input logic keep_valid);
    if (!keep_valid) next_slot();
    vset_valid = 1'b1;
    vset_avl   = avl;
    vset_vtype = vtype;
  endtask

  task automatic vset_readback(input xlen_t exp_vl, input xlen_t exp_vtype);
    read_csr(`VEC_CSR_ADDR_VL, exp_vl, 1'b0);
    read_csr(`VEC_CSR_ADDR_VTYPE, exp_vtype, 1'b0);
  endtask

  task automatic commit_op(input logic flush, input logic [3:0] exc, input xlen_t tval,
                           input logic exp_mode);
    next_slot();
    commit_valid       = 1'b1;
    commit_flush       = flush;
    commit_except_type = except_type_t'(exc);
    commit_tval        = tval;
    next_slot();  // commit taken at this edge
    @(negedge clk);
    check_value("o_lmul_exception_mode", xlen_t'(lmul_mode), xlen_t'(exp_mode));
  endtask

  task automatic need_fields(input int got, input int want, input string op);
    if (got != want) abort_run({"malformed stimulus line for op ", op});
  endtask

  initial begin : main
    int    fd;
    int    code;
    string op;
    string rest;
    xlen_t f[7];
    set_idle();
    fd = $fopen("test/vec_csr_stimulus.txt", "r");
    if (fd == 0) abort_run("cannot open test/vec_csr_stimulus.txt");
    wait_reset();
    forever begin
      code = $fscanf(fd, " %s", op);
      if (code != 1) break;
      case (op)
        "#": code = $fgets(rest, fd);  // comment line
        "R": begin
          need_fields($fscanf(fd, " %h %h %h", f[0], f[1], f[2]), 3, op);
          read_csr(f[0][11:0], f[1], f[2][0]);
        end
        "W": begin
          need_fields($fscanf(fd, " %h %h %h", f[0], f[1], f[2]), 3, op);
          write_csr(f[0][11:0], f[1], f[2][0]);
        end
        "V": begin
          need_fields($fscanf(fd, " %h %h %h %h", f[0], f[1], f[2], f[3]), 4, op);
          vset_request(f[0], f[1], 1'b0);
          next_slot();
          wait_done();
          check_value("o_vset_vl", xlen_t'(vset_vl), f[2]);
          vset_readback(f[2], f[3]);
        end
        "B": begin  // two strobes back to back
          need_fields($fscanf(fd, " %h %h %h %h %h %h %h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6]), 7, op);
          vset_request(f[0], f[1], 1'b0);
          @(posedge clk);
          #1 vset_request(f[3], f[4], 1'b1);
          wait_done();
          check_value("o_vset_vl", xlen_t'(vset_vl), f[2]);
          next_slot();
          wait_done();
          check_value("o_vset_vl", xlen_t'(vset_vl), f[5]);
          vset_readback(f[5], f[6]);
        end
        "C": begin
          need_fields($fscanf(fd, " %h %h %h %h", f[0], f[1], f[2], f[3]), 4, op);
          commit_op(f[0][0], f[1][3:0], f[2], f[3][0]);
        end
        default: abort_run({"unknown op in stimulus file: ", op});
      endcase
    end
    $fclose(fd);
    next_slot();
    $display("Regression passed");
    $finish;
  end

endmodule

//--- vec_csr_top.f
+incdir+design
design/vec_csr_pkg.sv
design/vsetvl_unit.sv
design/vec_csr_file.sv
design/vec_csr_top.sv
test/vec_csr_clkgen.sv
test/vec_csr_assertions.sv
test/vec_csr_tb.sv

//--- test/vec_csr_stimulus.txt
# R addr exp_data exp_err | W addr data exp_err | C flush exc tval exp_mode | V avl vtype exp_vl exp_vtype
# B avl1 vtype1 exp_vl1 avl2 vtype2 exp_vl2 exp_vtype2, all fields hex
# reset values
R 008 0 0
R 009 0 0
R 00a 0 0
R 00f 0 0
R c20 0 0
R c21 8000000000000000 0
R c22 10 0
R 800 0 0
R 123 0 1
# writable CSRs and the vcsr view
W 008 ab 0
R 008 ab 0
W 00a 3 0
R 00f 6 0
W 009 ff 0
R 00f 7 0
W 00f 2 0
R 00a 1 0
R 009 0 0
W 800 deadbeefcafef00d 0
R 800 deadbeefcafef00d 0
# read-only and unknown writes
W c20 5 1
W c21 0 1
W c22 0 1
W 7ff 1 1
R c20 0 0
R c21 8000000000000000 0
# legal: m1 e8, m2 e16, m8 e8 ta ma, mf2 e8, mf4 e16, mf8 e8, m4 e64
V a 0 a 0
V 20 9 10 9
V 100 c3 80 c3
V 5 7 5 7
V 9 e 2 e
V 40 5 2 5
V 3 1a 3 1a
# vill: vlmul 4, vsew 5, reserved bit, mf8 e64
V 8 4 0 8000000000000000
V 8 28 0 8000000000000000
V 8 100 0 8000000000000000
V 8 1d 0 8000000000000000
# commit monitor
C 1 1 1234 1
R 800 1234 0
C 0 2 0 1
C 1 2 0 0
C 1 1 55 1
C 1 3 0 0
C 1 1 66 1
C 1 4 0 0
C 0 1 99 0
R 800 66 0
# back-to-back vsetvl
B a 0 a 20 9 10 9
